//--- src/vcache_prof_pkg.sv
`default_nettype none

package vcache_prof_pkg;

  // cache bank geometry that only shapes the packets
  localparam int way_width_lp        = 3;
  localparam int set_width_lp        = 7;
  localparam int offset_width_lp     = 3;
  localparam int id_width_lp         = 4;
  localparam int addr_width_lp       = 32;
  localparam int block_addr_width_lp = 27;

  // data memory request at the tag-lookup and MHU ports
  typedef struct packed {
    logic                       write_not_read;
    logic [way_width_lp-1:0]    way_id;
    logic [set_width_lp-1:0]    set_idx;
    logic [offset_width_lp-1:0] word_offset;
  } data_mem_pkt_s;

  typedef struct packed {
    logic                     write_not_read;
    logic [id_width_lp-1:0]   id;
    logic [addr_width_lp-1:0] addr;
  } miss_fifo_entry_s;

  typedef struct packed {
    logic                           write_not_read;
    logic [block_addr_width_lp-1:0] block_addr;
  } dma_pkt_s;

  // state of the victim way chosen by the MHU
  typedef struct packed {
    logic valid;
    logic dirty;
  } repl_info_s;

  // event kinds in the order they leave on the dump stream
  typedef enum logic [3:0] {
    ld_hit, st_hit,
    ld_hit_under_miss, st_hit_under_miss,
    ld_miss, st_miss,
    ld_mhu, st_mhu,
    dma_read_req, dma_write_req,
    replace_invalid, replace_valid, replace_dirty
  } prof_event_e;

  localparam int num_events_lp = 13;

  typedef enum logic {idle, send} dump_state_e;

  typedef logic [31:0] stat_word_t;

  // global counter, tag, then one word per event
  localparam int dump_words_lp = num_events_lp + 2;

endpackage

`default_nettype wire

//--- src/vcache_event_decode.sv
`default_nettype none

module vcache_event_decode
  import vcache_prof_pkg::*;
  (
    // tag-lookup data memory port
    input  data_mem_pkt_s                tl_pkt_i,
    input  logic                         tl_v_i,
    input  logic                         tl_ready_i,

    input  logic                         mhu_idle_i,

    // MHU data memory port
    input  data_mem_pkt_s                mhu_pkt_i,
    input  logic                         mhu_v_i,
    input  logic                         mhu_yumi_i,

    // miss FIFO enqueue
    input  miss_fifo_entry_s             miss_entry_i,
    input  logic                         miss_v_i,
    input  logic                         miss_ready_i,

    // DMA request port
    input  dma_pkt_s                     dma_pkt_i,
    input  logic                         dma_v_i,
    input  logic                         dma_yumi_i,

    // replacement decision
    input  logic                         dma_cmd_v_i,
    input  repl_info_s                   repl_i,

    output logic [num_events_lp-1:0]     events_o
  );

  logic tl_fire;
  logic mhu_fire;
  logic miss_fire;
  logic dma_fire;

  // a transfer happens only when both sides of the handshake agree
  assign tl_fire   = tl_v_i & tl_ready_i;
  assign mhu_fire  = mhu_v_i & mhu_yumi_i;
  assign miss_fire = miss_v_i & miss_ready_i;
  assign dma_fire  = dma_v_i & dma_yumi_i;

  always_comb begin
    events_o = '0;

    events_o[ld_hit] = tl_fire & ~tl_pkt_i.write_not_read;
    events_o[st_hit] = tl_fire &  tl_pkt_i.write_not_read;

    // subset of the hits above, taken while a miss is outstanding
    events_o[ld_hit_under_miss] = events_o[ld_hit] & ~mhu_idle_i;
    events_o[st_hit_under_miss] = events_o[st_hit] & ~mhu_idle_i;

    events_o[ld_miss] = miss_fire & ~miss_entry_i.write_not_read;
    events_o[st_miss] = miss_fire &  miss_entry_i.write_not_read;

    events_o[ld_mhu] = mhu_fire & ~mhu_pkt_i.write_not_read;
    events_o[st_mhu] = mhu_fire &  mhu_pkt_i.write_not_read;

    events_o[dma_read_req]  = dma_fire & ~dma_pkt_i.write_not_read;
    events_o[dma_write_req] = dma_fire &  dma_pkt_i.write_not_read;

    events_o[replace_invalid] = dma_cmd_v_i & ~repl_i.valid;
    events_o[replace_valid]   = dma_cmd_v_i &  repl_i.valid & ~repl_i.dirty;
    events_o[replace_dirty]   = dma_cmd_v_i &  repl_i.valid &  repl_i.dirty;
  end

endmodule

`default_nettype wire

//--- src/vcache_stat_counters.sv
`default_nettype none

module vcache_stat_counters
  import vcache_prof_pkg::*;
  #(
    parameter int count_width_p = 32
  )
  (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic [num_events_lp-1:0]                      events_i,
    output logic [num_events_lp-1:0][count_width_p-1:0]   counts_o
  );

  logic [num_events_lp-1:0][count_width_p-1:0] counts_r;
  logic [num_events_lp-1:0]                    sat;

  // a counter at all ones ignores further events
  always_comb begin
    for (int i = 0; i < num_events_lp; i++) begin
      sat[i] = &counts_r[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      counts_r <= '0;
    end else begin
      for (int i = 0; i < num_events_lp; i++) begin
        if (events_i[i] && !sat[i]) begin
          counts_r[i] <= counts_r[i] + 1'b1;
        end
      end
    end
  end

  // registered, so an event shows up one cycle later
  assign counts_o = counts_r;

endmodule

`default_nettype wire

//--- src/vcache_stat_dump.sv
`default_nettype none

module vcache_stat_dump
  import vcache_prof_pkg::*;
  #(
    parameter int count_width_p = 32,
    parameter int tag_width_p   = 32
  )
  (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic [num_events_lp-1:0][count_width_p-1:0]   counts_i,
    input  logic [31:0]                                   global_ctr_i,
    input  logic                                          print_stat_v_i,
    input  logic [tag_width_p-1:0]                        print_stat_tag_i,

    output logic                                          dump_v_o,
    output stat_word_t                                    dump_data_o,
    output logic                                          dump_last_o,
    output logic                                          busy_o
  );

  localparam int idx_width_lp = $clog2(dump_words_lp);
  localparam logic [idx_width_lp-1:0] last_idx_lp = idx_width_lp'(dump_words_lp - 1);

  dump_state_e              state_r;
  logic [idx_width_lp-1:0]  idx_r;
  logic                     print_accept;

  stat_word_t snap_r    [dump_words_lp];
  stat_word_t snap_next [dump_words_lp];

  // record holds the global counter, the tag, then the counters zero-extended
  always_comb begin
    for (int w = 0; w < dump_words_lp; w++) begin
      snap_next[w] = '0;
    end
    snap_next[0] = global_ctr_i;
    snap_next[1][tag_width_p-1:0] = print_stat_tag_i;
    for (int i = 0; i < num_events_lp; i++) begin
      snap_next[i+2][count_width_p-1:0] = counts_i[i];
    end
  end

  // strobes during a dump, including its last word, are dropped
  assign print_accept = (state_r == idle) & print_stat_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle;
      idx_r   <= '0;
    end else begin
      case (state_r)
        idle: begin
          idx_r <= '0;
          if (print_accept) begin
            state_r <= send;
          end
        end
        send: begin
          if (idx_r == last_idx_lp) begin
            state_r <= idle;
            idx_r   <= '0;
          end else begin
            idx_r <= idx_r + 1'b1;
          end
        end
        default: begin
          state_r <= idle;
          idx_r   <= '0;
        end
      endcase
    end
  end

  // record captured on an accepted print
  always_ff @(posedge clk_i) begin
    if (print_accept) begin
      snap_r <= snap_next;
    end
  end

  assign busy_o      = (state_r == send);
  assign dump_v_o    = (state_r == send);
  assign dump_last_o = (state_r == send) & (idx_r == last_idx_lp);
  assign dump_data_o = snap_r[idx_r];

endmodule

`default_nettype wire

//--- src/vcache_profiler.sv
`default_nettype none

module vcache_profiler
  import vcache_prof_pkg::*;
  #(
    parameter int count_width_p = 32,
    parameter int tag_width_p   = 32
  )
  (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // cache taps
    input  data_mem_pkt_s            tl_pkt_i,
    input  logic                     tl_v_i,
    input  logic                     tl_ready_i,
    input  logic                     mhu_idle_i,
    input  data_mem_pkt_s            mhu_pkt_i,
    input  logic                     mhu_v_i,
    input  logic                     mhu_yumi_i,
    input  miss_fifo_entry_s         miss_entry_i,
    input  logic                     miss_v_i,
    input  logic                     miss_ready_i,
    input  dma_pkt_s                 dma_pkt_i,
    input  logic                     dma_v_i,
    input  logic                     dma_yumi_i,
    input  logic                     dma_cmd_v_i,
    input  repl_info_s               repl_i,

    // print request
    input  logic [31:0]              global_ctr_i,
    input  logic                     print_stat_v_i,
    input  logic [tag_width_p-1:0]   print_stat_tag_i,

    // dump stream of one word per cycle without back-pressure
    output logic                     dump_v_o,
    output stat_word_t               dump_data_o,
    output logic                     dump_last_o,
    output logic                     busy_o
  );

  logic [num_events_lp-1:0]                    events;
  logic [num_events_lp-1:0][count_width_p-1:0] counts;

  vcache_event_decode decode (
    .tl_pkt_i     (tl_pkt_i),
    .tl_v_i       (tl_v_i),
    .tl_ready_i   (tl_ready_i),
    .mhu_idle_i   (mhu_idle_i),
    .mhu_pkt_i    (mhu_pkt_i),
    .mhu_v_i      (mhu_v_i),
    .mhu_yumi_i   (mhu_yumi_i),
    .miss_entry_i (miss_entry_i),
    .miss_v_i     (miss_v_i),
    .miss_ready_i (miss_ready_i),
    .dma_pkt_i    (dma_pkt_i),
    .dma_v_i      (dma_v_i),
    .dma_yumi_i   (dma_yumi_i),
    .dma_cmd_v_i  (dma_cmd_v_i),
    .repl_i       (repl_i),
    .events_o     (events)
  );

  vcache_stat_counters #(
    .count_width_p (count_width_p)
  ) counters (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .events_i (events),
    .counts_o (counts)
  );

  vcache_stat_dump #(
    .count_width_p (count_width_p),
    .tag_width_p   (tag_width_p)
  ) dump (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .counts_i         (counts),
    .global_ctr_i     (global_ctr_i),
    .print_stat_v_i   (print_stat_v_i),
    .print_stat_tag_i (print_stat_tag_i),
    .dump_v_o         (dump_v_o),
    .dump_data_o      (dump_data_o),
    .dump_last_o      (dump_last_o),
    .busy_o           (busy_o)
  );

endmodule

`default_nettype wire

//--- testbench/vcache_profiler_sva.sv
`default_nettype none

module vcache_profiler_sva (
    input logic clk_i,
    input logic reset_i,
    input logic print_stat_v_i,
    input logic dump_v_o,
    input logic dump_last_o,
    input logic busy_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  last_has_valid: assert property (@(posedge clk_i) dump_last_o |-> dump_v_o)
    else begin
      fail_count++;
      $error("dump_last_o high without dump_v_o");
    end

  busy_matches_valid: assert property (@(posedge clk_i) busy_o == dump_v_o)
    else begin
      fail_count++;
      $error("busy_o differs from dump_v_o");
    end

  // an accepted print gives fifteen words, the last one flagged
  print_gives_record: assert property (@(posedge clk_i) disable iff (reset_i)
      (print_stat_v_i && !busy_o) |=> dump_v_o ##14 (dump_v_o && dump_last_o) ##1 !dump_v_o)
    else begin
      fail_count++;
      $error("record after print is not fifteen words ending in last");
    end

  stream_unbroken: assert property (@(posedge clk_i) disable iff (reset_i)
      (dump_v_o && !dump_last_o) |=> dump_v_o)
    else begin
      fail_count++;
      $error("dump stream has a gap before its last word");
    end

  reset_clears: assert property (@(posedge clk_i)
      reset_i |=> (!dump_v_o && !busy_o && !dump_last_o))
    else begin
      fail_count++;
      $error("dump outputs not low during reset");
    end

endmodule

bind vcache_profiler vcache_profiler_sva dump_checks (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .print_stat_v_i (print_stat_v_i),
  .dump_v_o       (dump_v_o),
  .dump_last_o    (dump_last_o),
  .busy_o         (busy_o)
);

`default_nettype wire

//--- testbench/vcache_profiler_tb.sv
`default_nettype none

module vcache_profiler_tb
  import vcache_prof_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int count_width_lp = 8;
  localparam int count_max_lp   = (1 << count_width_lp) - 1;
  localparam int timeout_lp     = 20;

  logic             clk_i;
  logic             reset_i;
  data_mem_pkt_s    tl_pkt_i;
  logic             tl_v_i, tl_ready_i;
  logic             mhu_idle_i;
  data_mem_pkt_s    mhu_pkt_i;
  logic             mhu_v_i, mhu_yumi_i;
  miss_fifo_entry_s miss_entry_i;
  logic             miss_v_i, miss_ready_i;
  dma_pkt_s         dma_pkt_i;
  logic             dma_v_i, dma_yumi_i;
  logic             dma_cmd_v_i;
  repl_info_s       repl_i;
  logic [31:0]      global_ctr_i;
  logic             print_stat_v_i;
  logic [31:0]      print_stat_tag_i;
  logic             dump_v_o;
  stat_word_t       dump_data_o;
  logic             dump_last_o;
  logic             busy_o;

  int         lcg_state = 65;
  int         fd;
  int         model_cnt [num_events_lp];
  stat_word_t snap [dump_words_lp];

  vcache_profiler #(
    .count_width_p (count_width_lp),
    .tag_width_p   (32)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 1103515245 + 12345;
    return lcg_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch at %0d ns: %s, got %0h, expected %0h",
                         $time, what, actual, expected));
    end
  endtask

  // inputs change shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle_inputs();
    {tl_v_i, tl_ready_i, mhu_v_i, mhu_yumi_i} = '0;
    {miss_v_i, miss_ready_i, dma_v_i, dma_yumi_i} = '0;
    dma_cmd_v_i    = 1'b0;
    repl_i         = '0;
    mhu_idle_i     = 1'b1;
    print_stat_v_i = 1'b0;
  endtask

  // which events the current tap values should raise
  function automatic logic [num_events_lp-1:0] expected_events();
    logic [num_events_lp-1:0] ev;
    ev = '0;
    if (tl_v_i && tl_ready_i) begin
      ev[tl_pkt_i.write_not_read ? st_hit : ld_hit] = 1'b1;
      ev[tl_pkt_i.write_not_read ? st_hit_under_miss : ld_hit_under_miss] = !mhu_idle_i;
    end
    if (miss_v_i && miss_ready_i) begin
      ev[miss_entry_i.write_not_read ? st_miss : ld_miss] = 1'b1;
    end
    if (mhu_v_i && mhu_yumi_i) begin
      ev[mhu_pkt_i.write_not_read ? st_mhu : ld_mhu] = 1'b1;
    end
    if (dma_v_i && dma_yumi_i) begin
      ev[dma_pkt_i.write_not_read ? dma_write_req : dma_read_req] = 1'b1;
    end
    if (dma_cmd_v_i) begin
      case ({repl_i.valid, repl_i.dirty})
        2'b10:   ev[replace_valid] = 1'b1;
        2'b11:   ev[replace_dirty] = 1'b1;
        default: ev[replace_invalid] = 1'b1;
      endcase
    end
    return ev;
  endfunction

  task automatic count_cycle();
    logic [num_events_lp-1:0] ev;
    ev = expected_events();
    for (int i = 0; i < num_events_lp; i++) begin
      if (ev[i] && model_cnt[i] < count_max_lp) begin
        model_cnt[i]++;
      end
    end
  endtask

  task automatic drive_taps();
    int          n;
    logic [2:0]  tl_f, mhu_f, miss_f, dma_f, repl_f;
    logic        idle_f;
    logic [31:0] rnd;
    if ($fscanf(fd, "%d %b %b %b %b %b %b", n, tl_f, idle_f, mhu_f, miss_f, dma_f,
                repl_f) != 7) begin
      fail_run("stim file has a malformed tap line");
    end
    repeat (n) begin
      next_cycle();
      idle_inputs();
      // way, set and offset bits are noise to the profiler
      rnd       = lcg_next();
      tl_pkt_i  = rnd[13:0];
      mhu_pkt_i = rnd[31:18];
      {tl_v_i, tl_ready_i, tl_pkt_i.write_not_read} = tl_f;
      mhu_idle_i = idle_f;
      {mhu_v_i, mhu_yumi_i, mhu_pkt_i.write_not_read} = mhu_f;
      {miss_v_i, miss_ready_i, miss_entry_i.write_not_read} = miss_f;
      {dma_v_i, dma_yumi_i, dma_pkt_i.write_not_read} = dma_f;
      {dma_cmd_v_i, repl_i.valid, repl_i.dirty} = repl_f;
      count_cycle();
    end
  endtask

  // taps keep the values of the line before, so the print cycle can count too
  task automatic issue_print();
    logic [31:0] tag;
    logic [31:0] gctr;
    if ($fscanf(fd, "%h %h", tag, gctr) != 2) begin
      fail_run("stim file has a malformed print line");
    end
    next_cycle();
    print_stat_v_i   = 1'b1;
    print_stat_tag_i = tag;
    global_ctr_i     = gctr;
    snap[0] = gctr;
    snap[1] = tag;
    for (int i = 0; i < num_events_lp; i++) begin
      snap[i+2] = model_cnt[i];
    end
    count_cycle();
  endtask

  task automatic verify_record();
    stat_word_t words [dump_words_lp];
    int         cyc;
    for (int w = 0; w < dump_words_lp; w++) begin
      if ($fscanf(fd, "%h", words[w]) != 1) begin
        fail_run("stim file has a short expect line");
      end
      check(words[w], snap[w], $sformatf("model word %0d of the record", w));
    end
    cyc = 0;
    next_cycle();
    idle_inputs();
    while (!dump_v_o) begin
      if (cyc == timeout_lp) begin
        fail_run("dump never started after the print request");
      end
      next_cycle();
      idle_inputs();
      cyc++;
    end
    check(cyc, 0, "extra cycles from print to first word");
    for (int w = 0; w < dump_words_lp; w++) begin
      if (w > 0) begin
        next_cycle();
      end
      check(32'(dump_v_o), 1, $sformatf("dump_v_o on word %0d", w));
      check(32'(dump_last_o), 32'(w == dump_words_lp - 1),
            $sformatf("dump_last_o on word %0d", w));
      check(dump_data_o, words[w], $sformatf("dump word %0d", w));
      // prints while busy, the last word too, have to be dropped
      print_stat_v_i = 1'b1;
    end
    next_cycle();
    idle_inputs();
    check(32'(dump_v_o), 0, "dump_v_o after the last word");
  endtask

  task automatic reset_mid_stream();
    int n;
    if ($fscanf(fd, "%d", n) != 1) begin
      fail_run("stim file has a malformed reset line");
    end
    next_cycle();
    idle_inputs();
    check(32'(dump_v_o), 1, "dump_v_o before the reset");
    reset_i        = 1'b1;
    print_stat_v_i = 1'b1;
    repeat (n) begin
      next_cycle();
      check(32'({dump_v_o, busy_o, dump_last_o}), 0, "dump outputs in reset");
    end
    reset_i        = 1'b0;
    print_stat_v_i = 1'b0;
    for (int i = 0; i < num_events_lp; i++) begin
      model_cnt[i] = 0;
    end
  endtask

  initial begin
    byte              kind;
    logic [8*128-1:0] comment;
    reset_i          = 1'b1;
    idle_inputs();
    tl_pkt_i         = '0;
    mhu_pkt_i        = '0;
    miss_entry_i     = '0;
    dma_pkt_i        = '0;
    global_ctr_i     = '0;
    print_stat_tag_i = '0;
    for (int i = 0; i < num_events_lp; i++) begin
      model_cnt[i] = 0;
    end
    repeat (4) next_cycle();
    reset_i = 1'b0;

    fd = $fopen("testbench/vcache_profiler_stim.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open testbench/vcache_profiler_stim.txt");
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": void'($fgets(comment, fd));
        "t": begin
          // idle gap of random length before each burst of tap cycles
          repeat (lcg_next() >> 29) begin
            next_cycle();
            idle_inputs();
          end
          drive_taps();
        end
        "p": issue_print();
        "e": verify_record();
        "r": reset_mid_stream();
        default: fail_run($sformatf("unknown stim line kind '%c'", kind));
      endcase
    end
    $fclose(fd);
    repeat (2) next_cycle();

    if (dut.dump_checks.fail_count != 0) begin
      $display("%0d assertion failures on the dump port", dut.dump_checks.fail_count);
      $display("tests failed");
      $fatal(1, "assertions on the dump port failed");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vcache_prof.f
src/vcache_prof_pkg.sv
src/vcache_event_decode.sv
src/vcache_stat_counters.sv
src/vcache_stat_dump.sv
src/vcache_profiler.sv
testbench/vcache_profiler_sva.sv
testbench/vcache_profiler_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vcache_profiler_tb
FILELIST  ?= vcache_prof.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/vcache_profiler_stim.txt
# t cycles tl(v rdy wr) mhu_idle mhu(v yumi wr) miss(v rdy wr) dma(v yumi wr) repl(cmd vld dirty)
# p tag gctr | e gctr tag then 13 counts, hex | r reset cycles
# hit classification
t 3 110 1 000 000 000 000
t 2 111 1 000 000 000 000
t 2 100 1 000 000 000 000
# hits under a miss, the print cycle hit is left out of the record
t 2 110 0 000 000 000 000
t 1 111 0 000 000 000 000
p 0000a001 00000100
e 00000100 0000a001 5 3 2 1 0 0 0 0 0 0 0 0 0
# misses, MHU and DMA, several in the same cycle
t 2 110 1 111 110 110 000
t 1 000 1 101 101 101 000
t 3 000 1 110 111 111 000
# replacement only counts with dma_cmd_v
t 2 000 1 000 000 000 011
t 1 000 1 000 000 000 101
t 2 000 1 000 000 000 110
t 3 000 1 000 000 000 111
p 0000b002 00000200
e 00000200 0000b002 7 4 2 2 2 3 3 2 2 3 1 2 3
# 8-bit load-hit counter stops at all ones
t 300 110 1 000 000 000 000
p 0000c003 00001000
e 00001000 0000c003 ff 4 2 2 2 3 3 2 2 3 1 2 4
# reset while a record is on its way out
p 0000dead 00002000
r 2
t 1 111 0 000 000 000 000
p 00000001 00003000
e 00003000 00000001 0 1 0 1 0 0 0 0 0 0 0 0 0
